// ==== flist.f ====
verilog/soc_pkg.sv
verilog/bus_stall_lfsr.sv
verilog/soc_ram.sv
verilog/soc_serial_port.sv
verilog/soc_bus_slave.sv
verilog/soc_top.sv
bench/soc_sva.sv
bench/tb_soc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_soc \
  -Mdir obj_dir -o sim_tb_soc
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb_soc +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

// ==== bench/tb_soc.sv ====
module tb_soc;
  import soc_pkg::*;

  // about 64 transactions, each well under 60 cycles with stalls
  localparam int TXN_COUNT      = 64;
  localparam int TXN_CYCLES     = 60;
  localparam int TIMEOUT_CYCLES = TXN_COUNT * TXN_CYCLES + 160;

  logic              clk;
  logic              reset_i;
  logic [ADDR_W-1:0] araddr_i;
  logic              arvalid_i;
  logic              arready_o;
  logic [DATA_W-1:0] rdata_o;
  logic [1:0]        rresp_o;
  logic              rvalid_o;
  logic              rready_i;
  logic [ADDR_W-1:0] awaddr_i;
  logic              awvalid_i;
  logic              awready_o;
  logic [DATA_W-1:0] wdata_i;
  logic [STRB_W-1:0] wstrb_i;
  logic              wvalid_i;
  logic              wready_o;
  logic [1:0]        bresp_o;
  logic              bvalid_o;
  logic              bready_i;
  logic [7:0]        serial_data_o;
  logic              serial_valid_o;

  integer            seed;
  int                errors = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  int                cycles = 0;
  logic [DATA_W-1:0] shadow [MEM_WORDS];
  logic [DATA_W-1:0] sent_total;
  logic [7:0]        sent_q [$];
  logic [7:0]        seen_q [$];
  int                written_q [$];

  soc_top DUT (.*);

  bind soc_top soc_sva u_sva (
    .clk            (clk),
    .reset_i        (reset_i),
    .arvalid_i      (arvalid_i),
    .arready_i      (arready_o),
    .rdata_i        (rdata_o),
    .rresp_i        (rresp_o),
    .rvalid_i       (rvalid_o),
    .rready_i       (rready_i),
    .awready_i      (awready_o),
    .wvalid_i       (wvalid_i),
    .wready_i       (wready_o),
    .bresp_i        (bresp_o),
    .bvalid_i       (bvalid_o),
    .bready_i       (bready_i),
    .serial_valid_i (serial_valid_o)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  // serial bytes as they leave the port
  always @(negedge clk) begin
    if (!reset_i && serial_valid_o) begin
      seen_q.push_back(serial_data_o);
    end
  end

  function automatic logic [ADDR_W-1:0] mem_addr(input int idx);
    return MEM_BASE + ADDR_W'(idx * STRB_W);
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] nval,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] m;
    m = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        m[8*b +: 8] = nval[8*b +: 8];
      end
    end
    return m;
  endfunction

  task automatic check_eq(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] got);
    assert (got === exp)
    else begin
      $display("mismatch %s: expected %h, actual %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input resp_e exp, input logic [1:0] got);
    assert (got === exp)
    else begin
      $display("mismatch %s: expected %h, actual %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, output logic [1:0] resp);
    int dly;
    dly = $unsigned($random(seed)) % 4;
    @(posedge clk);
    awaddr_i  <= addr;
    awvalid_i <= 1'b1;
    @(negedge clk);
    while (!awready_o) @(negedge clk);
    @(posedge clk);
    awvalid_i <= 1'b0;
    wdata_i   <= data;
    wstrb_i   <= strb;
    wvalid_i  <= 1'b1;
    @(negedge clk);
    while (!wready_o) @(negedge clk);
    @(posedge clk);
    wvalid_i <= 1'b0;
    @(negedge clk);
    while (!bvalid_o) @(negedge clk);
    // hold off bready to exercise back-pressure
    repeat (dly) @(negedge clk);
    resp = bresp_o;
    @(posedge clk);
    bready_i <= 1'b1;
    @(posedge clk);
    bready_i <= 1'b0;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic [1:0] resp);
    int dly;
    dly = $unsigned($random(seed)) % 4;
    @(posedge clk);
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    @(negedge clk);
    while (!arready_o) @(negedge clk);
    @(posedge clk);
    arvalid_i <= 1'b0;
    @(negedge clk);
    while (!rvalid_o) @(negedge clk);
    repeat (dly) @(negedge clk);
    data = rdata_o;
    resp = rresp_o;
    @(posedge clk);
    rready_i <= 1'b1;
    @(posedge clk);
    rready_i <= 1'b0;
  endtask

  task automatic compare_serial();
    assert (seen_q.size() == sent_q.size())
    else begin
      $display("serial port sent %0d bytes where %0d were written", seen_q.size(),
               sent_q.size());
      errors++;
    end
    while (seen_q.size() > 0 && sent_q.size() > 0) begin
      check_eq("serial_data_o", DATA_W'(sent_q.pop_front()), DATA_W'(seen_q.pop_front()));
    end
    seen_q.delete();
    sent_q.delete();
  endtask

  task automatic recheck_ram();
    logic [DATA_W-1:0] rd;
    logic [1:0]        resp;
    foreach (written_q[i]) begin
      bus_read(mem_addr(written_q[i]), rd, resp);
      check_eq("rdata_o", shadow[written_q[i]], rd);
      check_resp("rresp_o", RESP_OKAY, resp);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] rd;
    logic [STRB_W-1:0] strb;
    logic [1:0]        resp;
    int                idx;
    int                mark;
    int unsigned       sva_fails;
    seed       = 32'ha005_7e33;
    sent_total = '0;
    reset_i    = 1'b1;
    araddr_i   = '0;
    arvalid_i  = 1'b0;
    rready_i   = 1'b0;
    awaddr_i   = '0;
    awvalid_i  = 1'b0;
    wdata_i    = '0;
    wstrb_i    = '0;
    wvalid_i   = 1'b0;
    bready_i   = 1'b0;
    repeat (5) @(posedge clk);
    reset_i <= 1'b0;

    mark = errors;
    for (int i = 0; i < 8; i++) begin
      // word 0 always included since unmapped writes alias to it
      idx  = (i == 0) ? 0 : int'($unsigned($random(seed)) % MEM_WORDS);
      data = {$random(seed), $random(seed)};
      bus_write(mem_addr(idx), data, '1, resp);
      check_resp("bresp_o", RESP_OKAY, resp);
      shadow[idx] = data;
      written_q.push_back(idx);
    end
    recheck_ram();
    end_test("ram_roundtrip", mark);

    mark = errors;
    for (int i = 0; i < 6; i++) begin
      idx  = written_q[$unsigned($random(seed)) % written_q.size()];
      data = {$random(seed), $random(seed)};
      strb = STRB_W'($random(seed));
      bus_write(mem_addr(idx), data, strb, resp);
      check_resp("bresp_o", RESP_OKAY, resp);
      shadow[idx] = merge_bytes(shadow[idx], data, strb);
      bus_read(mem_addr(idx), rd, resp);
      check_eq("rdata_o", shadow[idx], rd);
    end
    end_test("partial_strobe", mark);

    mark = errors;
    for (int i = 0; i < 5; i++) begin
      data = {$random(seed), $random(seed)};
      bus_write(SERIAL_ADDR, data, '1, resp);
      check_resp("bresp_o", RESP_OKAY, resp);
      sent_q.push_back(data[7:0]);
      sent_total = sent_total + 1;
    end
    compare_serial();
    bus_read(SERIAL_ADDR, rd, resp);
    check_eq("rdata_o", sent_total, rd);
    check_resp("rresp_o", RESP_OKAY, resp);
    end_test("serial_port", mark);

    mark = errors;
    data = {$random(seed), $random(seed)};
    bus_write(32'h2000_0000, data, '1, resp);
    check_resp("bresp_o", RESP_DECERR, resp);
    bus_write(mem_addr(MEM_WORDS), data, '1, resp);
    check_resp("bresp_o", RESP_DECERR, resp);
    bus_write(SERIAL_ADDR + 32'd8, data, '1, resp);
    check_resp("bresp_o", RESP_DECERR, resp);
    bus_read(32'h2000_0000, rd, resp);
    check_resp("rresp_o", RESP_DECERR, resp);
    check_eq("rdata_o", '0, rd);
    bus_read(mem_addr(MEM_WORDS), rd, resp);
    check_resp("rresp_o", RESP_DECERR, resp);
    check_eq("rdata_o", '0, rd);
    compare_serial();
    bus_read(SERIAL_ADDR, rd, resp);
    check_eq("rdata_o", sent_total, rd);
    recheck_ram();
    end_test("decode_error", mark);

    mark = errors;
    for (int i = 0; i < 12; i++) begin
      idx = written_q[$unsigned($random(seed)) % written_q.size()];
      if ($random(seed) & 1) begin
        data = {$random(seed), $random(seed)};
        strb = STRB_W'($random(seed));
        bus_write(mem_addr(idx), data, strb, resp);
        check_resp("bresp_o", RESP_OKAY, resp);
        shadow[idx] = merge_bytes(shadow[idx], data, strb);
      end else begin
        bus_read(mem_addr(idx), rd, resp);
        check_eq("rdata_o", shadow[idx], rd);
        check_resp("rresp_o", RESP_OKAY, resp);
      end
    end
    end_test("mixed_traffic", mark);

    sva_fails = DUT.u_sva.fail_count;
    $display("tests: %0d run, %0d failed, %0d data errors, %0d protocol errors",
             tests_run, tests_failed, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== bench/soc_sva.sv ====
module soc_sva (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       arvalid_i,
  input  logic                       arready_i,
  input  logic [soc_pkg::DATA_W-1:0] rdata_i,
  input  logic [1:0]                 rresp_i,
  input  logic                       rvalid_i,
  input  logic                       rready_i,
  input  logic                       awready_i,
  input  logic                       wvalid_i,
  input  logic                       wready_i,
  input  logic [1:0]                 bresp_i,
  input  logic                       bvalid_i,
  input  logic                       bready_i,
  input  logic                       serial_valid_i
);
  import soc_pkg::*;

  int unsigned fail_count = 0;

  // nothing ready or valid in the cycle after a reset edge
  reset_quiet: assert property (@(posedge clk)
    reset_i |=> !(arready_i || awready_i || wready_i || rvalid_i || bvalid_i || serial_valid_i))
    else begin
      fail_count = fail_count + 1;
      $error("bus outputs active right after reset");
    end

  r_hold: assert property (@(posedge clk) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      fail_count = fail_count + 1;
      $error("read response changed before rready");
    end

  b_hold: assert property (@(posedge clk) disable iff (reset_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      fail_count = fail_count + 1;
      $error("write response changed before bready");
    end

  // rvalid exactly one cycle after the address
  r_follows_ar: assert property (@(posedge clk) disable iff (reset_i)
    $rose(rvalid_i) == $past(arvalid_i && arready_i))
    else begin
      fail_count = fail_count + 1;
      $error("rvalid not one cycle after the read address handshake");
    end

  b_follows_w: assert property (@(posedge clk) disable iff (reset_i)
    $rose(bvalid_i) == $past(wvalid_i && wready_i))
    else begin
      fail_count = fail_count + 1;
      $error("bvalid not one cycle after the write data handshake");
    end

  serial_pulse: assert property (@(posedge clk) disable iff (reset_i)
    serial_valid_i |-> $past(wvalid_i && wready_i) && !$past(serial_valid_i))
    else begin
      fail_count = fail_count + 1;
      $error("serial strobe not a single pulse after a write");
    end

  decerr_zero: assert property (@(posedge clk) disable iff (reset_i)
    rvalid_i && rresp_i == RESP_DECERR |-> rdata_i == '0)
    else begin
      fail_count = fail_count + 1;
      $error("decode error read returned nonzero data");
    end

endmodule

// ==== verilog/soc_top.sv ====
module soc_top (
  input  logic                       clk,
  input  logic                       reset_i,

  input  logic [soc_pkg::ADDR_W-1:0] araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,

  output logic [soc_pkg::DATA_W-1:0] rdata_o,
  output logic [1:0]                 rresp_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,

  input  logic [soc_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,

  input  logic [soc_pkg::DATA_W-1:0] wdata_i,
  input  logic [soc_pkg::STRB_W-1:0] wstrb_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,

  output logic [1:0]                 bresp_o,
  output logic                       bvalid_o,
  input  logic                       bready_i,

  output logic [7:0]                 serial_data_o,
  output logic                       serial_valid_o
);
  import soc_pkg::*;

  logic                 accept_ok;
  logic                 ram_we;
  logic [STRB_W-1:0]    ram_wstrb;
  logic [MEM_IDX_W-1:0] ram_widx;
  logic [DATA_W-1:0]    ram_wdata;
  logic                 ram_re;
  logic [MEM_IDX_W-1:0] ram_ridx;
  logic [DATA_W-1:0]    ram_rdata;
  logic                 ser_send;
  logic [7:0]           ser_byte;
  logic [31:0]          ser_count;

  soc_bus_slave u_slave (
    .clk         (clk),
    .reset_i     (reset_i),
    .accept_ok_i (accept_ok),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .ram_we_o    (ram_we),
    .ram_wstrb_o (ram_wstrb),
    .ram_widx_o  (ram_widx),
    .ram_wdata_o (ram_wdata),
    .ram_re_o    (ram_re),
    .ram_ridx_o  (ram_ridx),
    .ram_rdata_i (ram_rdata),
    .ser_send_o  (ser_send),
    .ser_byte_o  (ser_byte),
    .ser_count_i (ser_count)
  );

  bus_stall_lfsr u_lfsr (
    .clk         (clk),
    .reset_i     (reset_i),
    .accept_ok_o (accept_ok)
  );

  soc_ram u_ram (
    .clk     (clk),
    .we_i    (ram_we),
    .wstrb_i (ram_wstrb),
    .widx_i  (ram_widx),
    .wdata_i (ram_wdata),
    .re_i    (ram_re),
    .ridx_i  (ram_ridx),
    .rdata_o (ram_rdata)
  );

  soc_serial_port u_serial (
    .clk            (clk),
    .reset_i        (reset_i),
    .send_i         (ser_send),
    .byte_i         (ser_byte),
    .serial_data_o  (serial_data_o),
    .serial_valid_o (serial_valid_o),
    .sent_count_o   (ser_count)
  );

endmodule

// ==== verilog/soc_bus_slave.sv ====
module soc_bus_slave (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          accept_ok_i,

  input  logic [soc_pkg::ADDR_W-1:0]    araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,

  output logic [soc_pkg::DATA_W-1:0]    rdata_o,
  output logic [1:0]                    rresp_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,

  input  logic [soc_pkg::ADDR_W-1:0]    awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,

  input  logic [soc_pkg::DATA_W-1:0]    wdata_i,
  input  logic [soc_pkg::STRB_W-1:0]    wstrb_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,

  output logic [1:0]                    bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,

  output logic                          ram_we_o,
  output logic [soc_pkg::STRB_W-1:0]    ram_wstrb_o,
  output logic [soc_pkg::MEM_IDX_W-1:0] ram_widx_o,
  output logic [soc_pkg::DATA_W-1:0]    ram_wdata_o,
  output logic                          ram_re_o,
  output logic [soc_pkg::MEM_IDX_W-1:0] ram_ridx_o,
  input  logic [soc_pkg::DATA_W-1:0]    ram_rdata_i,

  output logic                          ser_send_o,
  output logic [7:0]                    ser_byte_o,
  input  logic [31:0]                   ser_count_i
);
  import soc_pkg::*;

  bus_state_e           state_q;
  region_e              region_q;
  logic [MEM_IDX_W-1:0] idx_q;

  region_e ar_region;
  region_e aw_region;
  logic    ar_hs;
  logic    aw_hs;
  logic    w_hs;
  resp_e   resp;

  function automatic region_e decode(input logic [ADDR_W-1:0] addr);
    region_e r;
    if (addr >= MEM_BASE && addr < MEM_BASE + ADDR_W'(MEM_WORDS * STRB_W)) begin
      r = REG_MEM;
    end else if (addr == SERIAL_ADDR) begin
      r = REG_SERIAL;
    end else begin
      r = REG_NONE;
    end
    return r;
  endfunction

  assign ar_region = decode(araddr_i);
  assign aw_region = decode(awaddr_i);

  // read wins over write in idle
  assign arready_o = (state_q == ST_IDLE) && accept_ok_i;
  assign awready_o = (state_q == ST_IDLE) && accept_ok_i && !arvalid_i;
  assign wready_o  = (state_q == ST_WDATA) && accept_ok_i;

  assign ar_hs = arvalid_i && arready_o;
  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (ar_hs) begin
            state_q <= ST_RDATA;
          end else if (aw_hs) begin
            state_q <= ST_WDATA;
          end
        end
        ST_RDATA: begin
          if (rready_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_WDATA: begin
          if (w_hs) begin
            state_q <= ST_WRESP;
          end
        end
        ST_WRESP: begin
          if (bready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // target of the transaction in flight
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      region_q <= ar_region;
    end else if (aw_hs) begin
      region_q <= aw_region;
      idx_q    <= awaddr_i[3 +: MEM_IDX_W];
    end
  end

  // ram read launched on the address edge, data valid next cycle
  assign ram_re_o   = ar_hs && (ar_region == REG_MEM);
  assign ram_ridx_o = araddr_i[3 +: MEM_IDX_W];

  // commit happens on the W handshake edge
  assign ram_we_o    = w_hs && (region_q == REG_MEM);
  assign ram_wstrb_o = wstrb_i;
  assign ram_widx_o  = idx_q;
  assign ram_wdata_o = wdata_i;

  assign ser_send_o = w_hs && (region_q == REG_SERIAL);
  assign ser_byte_o = wdata_i[7:0];

  assign resp = (region_q == REG_NONE) ? RESP_DECERR : RESP_OKAY;

  assign rvalid_o = (state_q == ST_RDATA);
  assign rresp_o  = resp;
  always_comb begin
    case (region_q)
      REG_MEM:    rdata_o = ram_rdata_i;
      REG_SERIAL: rdata_o = {{(DATA_W - 32){1'b0}}, ser_count_i};
      default:    rdata_o = '0;
    endcase
  end

  assign bvalid_o = (state_q == ST_WRESP);
  assign bresp_o  = resp;

endmodule

// ==== verilog/soc_serial_port.sv ====
module soc_serial_port (
  input  logic        clk,
  input  logic        reset_i,

  input  logic        send_i,
  input  logic [7:0]  byte_i,

  output logic [7:0]  serial_data_o,
  output logic        serial_valid_o,
  output logic [31:0] sent_count_o
);

  // strobe and counter
  always_ff @(posedge clk) begin
    if (reset_i) begin
      serial_valid_o <= 1'b0;
      sent_count_o   <= 32'd0;
    end else begin
      serial_valid_o <= send_i;
      if (send_i) begin
        sent_count_o <= sent_count_o + 32'd1;
      end
    end
  end

  // byte register, valid only with the strobe
  always_ff @(posedge clk) begin
    if (send_i) begin
      serial_data_o <= byte_i;
    end
  end

endmodule

// ==== verilog/soc_ram.sv ====
module soc_ram (
  input  logic                         clk,

  input  logic                         we_i,
  input  logic [soc_pkg::STRB_W-1:0]    wstrb_i,
  input  logic [soc_pkg::MEM_IDX_W-1:0] widx_i,
  input  logic [soc_pkg::DATA_W-1:0]    wdata_i,

  input  logic                         re_i,
  input  logic [soc_pkg::MEM_IDX_W-1:0] ridx_i,
  output logic [soc_pkg::DATA_W-1:0]    rdata_o
);
  import soc_pkg::*;

  logic [DATA_W-1:0] mem [MEM_WORDS];

  // byte lane writes
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[widx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read register holds until next read
  always_ff @(posedge clk) begin
    if (re_i) begin
      rdata_o <= mem[ridx_i];
    end
  end

endmodule

// ==== verilog/bus_stall_lfsr.sv ====
module bus_stall_lfsr (
  input  logic clk,
  input  logic reset_i,
  output logic accept_ok_o
);
  import soc_pkg::*;

  logic [LFSR_W-1:0] lfsr_q;

  // fibonacci form, taps 19 and 18
  always_ff @(posedge clk) begin
    if (reset_i) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[LFSR_W-1] ^ lfsr_q[LFSR_W-2]};
    end
  end

  // msb gates acceptance when throttling is on
  assign accept_ok_o = STALL_EN ? lfsr_q[LFSR_W-1] : 1'b1;

endmodule

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;

  // ram region, word addressed
  localparam logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  // serial port, single address
  localparam logic [ADDR_W-1:0] SERIAL_ADDR = 32'h1000_0000;

  // accept throttle
  localparam int LFSR_W = 20;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 20'd101;
  localparam bit STALL_EN = 1'b1;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RDATA = 2'd1,
    ST_WDATA = 2'd2,
    ST_WRESP = 2'd3
  } bus_state_e;

  typedef enum logic [1:0] {
    REG_MEM    = 2'd0,
    REG_SERIAL = 2'd1,
    REG_NONE   = 2'd2
  } region_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_DECERR = 2'd3
  } resp_e;

endpackage
